// ==== rtl/synth_pkg.sv ====
`default_nettype none

package synth_pkg;

    localparam int ADR_W   = 7;   // register address bits
    localparam int DATA_W  = 8;
    localparam int WAVE_W  = 16;  // signed osc sample
    localparam int LEVEL_W = 8;

    typedef enum logic [1:0] {
        env_idle,
        env_attack,
        env_sustain,
        env_release
    } env_state_t;

    // which register block an address decodes to
    typedef enum logic [1:0] {
        blk_osc,   // phase increments
        blk_env,   // attack / release rates
        blk_mix,   // master level
        blk_none
    } reg_block_t;

    localparam logic [ADR_W-1:0] ADR_OSC_BASE = 7'h00;  // lo/hi byte pair per slot
    localparam logic [ADR_W-1:0] ADR_ATTACK   = 7'h20;
    localparam logic [ADR_W-1:0] ADR_RELEASE  = 7'h21;
    localparam logic [ADR_W-1:0] ADR_MASTER   = 7'h30;

endpackage

`default_nettype wire

// ==== rtl/slot_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module slot_sequencer #(
    parameter int VOICES      = 4,
    parameter int V_OSC       = 2,
    parameter int SLOT_W      = 3,
    parameter int DAC_CREDITS = 2
) (
    input  wire                audio_clk,
    input  wire                rst,
    input  wire                credit_return,
    output logic [SLOT_W-1:0]  slot,
    output logic               slot_valid,
    output logic               frame_start,
    output logic               frame_end,
    output logic               run
);

    localparam int C_W = $clog2(DAC_CREDITS + 1);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(VOICES * V_OSC - 1);

    logic [C_W-1:0] credits;
    logic [C_W-1:0] credits_nxt;

    assign frame_start = slot_valid && (slot == '0);
    assign frame_end   = slot_valid && (slot == LAST_SLOT);
    // one credit taken in the slot-0 cycle of every frame
    assign credits_nxt = credits + C_W'(credit_return) - C_W'(frame_start);

    always_ff @(posedge audio_clk) begin
        if (rst) begin
            credits    <= C_W'(DAC_CREDITS);
            run        <= 1'b0;
            slot       <= '0;
            slot_valid <= 1'b0;
        end else begin
            credits <= credits_nxt;
            run     <= (credits_nxt != '0);  // mirrors credit count
            if (slot_valid && !frame_end) begin
                slot <= slot + 1'b1;         // frame in progress always finishes
            end else if (run) begin
                slot       <= '0;
                slot_valid <= 1'b1;
            end else begin
                slot_valid <= 1'b0;          // hold until a credit comes back
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/note_latch.sv ====
`timescale 1ns/1ns
`default_nettype none

module note_latch #(
    parameter int VOICES = 4,
    parameter int V_OSC  = 2,
    parameter int SLOT_W = 3
) (
    input  wire                        audio_clk,
    input  wire                        rst,
    input  wire                        frame_start,
    input  wire  [VOICES-1:0]          keys_on,
    input  wire                        note_on,
    input  wire  [$clog2(VOICES)-1:0]  cur_key_adr,
    input  wire  [7:0]                 cur_vel_on,
    input  wire  [SLOT_W-1:0]          slot,
    input  wire                        slot_valid,
    output logic [VOICES-1:0]          reg_keys_on,
    output logic [7:0]                 velocity
);

    localparam int O_W = $clog2(V_OSC);

    logic [7:0]            pend_vel [VOICES];  // written by note_on
    logic [7:0]            cur_vel  [VOICES];  // committed at frame start
    logic [SLOT_W-O_W-1:0] voice;

    assign voice = slot[SLOT_W-1:O_W];

    always_ff @(posedge audio_clk) begin
        if (rst) begin
            for (int v = 0; v < VOICES; v++) begin
                pend_vel[v] <= '0;
                cur_vel[v]  <= '0;
            end
            reg_keys_on <= '0;
            velocity    <= '0;
        end else begin
            if (note_on) begin
                pend_vel[cur_key_adr] <= cur_vel_on;
            end
            if (frame_start) begin
                reg_keys_on <= keys_on;
                for (int v = 0; v < VOICES; v++) begin
                    cur_vel[v] <= pend_vel[v];
                end
            end
            // bypass on slot 0 so the whole frame sees the new value
            if (slot_valid) begin
                velocity <= frame_start ? pend_vel[voice] : cur_vel[voice];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/param_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module param_regs import synth_pkg::*; #(
    parameter int VOICES = 4,
    parameter int V_OSC  = 2,
    parameter int SLOT_W = 3
) (
    input  wire                audio_clk,
    input  wire                rst,
    input  wire                write,
    input  wire                read,
    input  wire  [ADR_W-1:0]   adr,
    input  wire  [DATA_W-1:0]  synth_data_in,
    input  wire  [SLOT_W-1:0]  slot,
    output logic [DATA_W-1:0]  synth_data_out,
    output logic [15:0]        phase_inc,
    output logic [7:0]         attack_rate,
    output logic [7:0]         release_rate,
    output logic [7:0]         master_level
);

    localparam int OSC_BYTES = 2 * VOICES * V_OSC;
    localparam int OB_W      = $clog2(OSC_BYTES);

    logic [DATA_W-1:0] osc_mem [OSC_BYTES];
    logic [ADR_W-1:0]  osc_ofs;
    logic [OB_W-1:0]   osc_idx;
    reg_block_t        blk;

    assign osc_ofs = adr - ADR_OSC_BASE;  // wraps high below the base
    assign osc_idx = osc_ofs[OB_W-1:0];

    always_comb begin
        if (osc_ofs < ADR_W'(OSC_BYTES)) begin
            blk = blk_osc;
        end else if (adr == ADR_ATTACK || adr == ADR_RELEASE) begin
            blk = blk_env;
        end else if (adr == ADR_MASTER) begin
            blk = blk_mix;
        end else begin
            blk = blk_none;
        end
    end

    always_ff @(posedge audio_clk) begin
        if (rst) begin
            for (int i = 0; i < OSC_BYTES; i++) begin
                osc_mem[i] <= '0;
            end
            attack_rate    <= '0;
            release_rate   <= '0;
            master_level   <= '0;
            synth_data_out <= '0;
        end else begin
            if (write) begin
                case (blk)
                    blk_osc: osc_mem[osc_idx] <= synth_data_in;
                    blk_env: begin
                        if (adr == ADR_ATTACK) begin
                            attack_rate <= synth_data_in;
                        end else begin
                            release_rate <= synth_data_in;
                        end
                    end
                    blk_mix: master_level <= synth_data_in;
                    default: ;                       // unmapped, dropped
                endcase
            end
            if (read) begin                          // held until next read
                case (blk)
                    blk_osc: synth_data_out <= osc_mem[osc_idx];
                    blk_env: synth_data_out <= (adr == ADR_ATTACK) ? attack_rate : release_rate;
                    blk_mix: synth_data_out <= master_level;
                    default: synth_data_out <= '0;
                endcase
            end
        end
    end

    // increment for the slot being presented this cycle
    assign phase_inc = {osc_mem[{slot, 1'b1}], osc_mem[{slot, 1'b0}]};

endmodule

`default_nettype wire

// ==== rtl/phase_accum.sv ====
`timescale 1ns/1ns
`default_nettype none

module phase_accum import synth_pkg::*; #(
    parameter int VOICES = 4,
    parameter int V_OSC  = 2,
    parameter int SLOT_W = 3
) (
    input  wire                       audio_clk,
    input  wire                       rst,
    input  wire  [SLOT_W-1:0]         slot,
    input  wire                       slot_valid,
    input  wire  [15:0]               phase_inc,
    output logic signed [WAVE_W-1:0]  wave
);

    localparam int SLOTS = VOICES * V_OSC;

    logic [15:0] phase [SLOTS];
    logic [15:0] cur;
    logic [14:0] fold;

    assign cur  = phase[slot];
    assign fold = cur[15] ? ~cur[14:0] : cur[14:0];  // second half mirrored

    always_ff @(posedge audio_clk) begin
        if (rst) begin
            for (int s = 0; s < SLOTS; s++) begin
                phase[s] <= '0;
            end
            wave <= '0;
        end else if (slot_valid) begin
            phase[slot] <= cur + phase_inc;
            // offset binary to two's complement, full swing
            wave <= {~fold[14], fold[13:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/env_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module env_gen import synth_pkg::*; #(
    parameter int VOICES = 4,
    parameter int V_OSC  = 2,
    parameter int SLOT_W = 3
) (
    input  wire                 audio_clk,
    input  wire                 rst,
    input  wire  [SLOT_W-1:0]   slot,
    input  wire                 slot_valid,
    input  wire  [VOICES-1:0]   reg_keys_on,
    input  wire  [7:0]          attack_rate,
    input  wire  [7:0]          release_rate,
    output logic [LEVEL_W-1:0]  level,
    output logic [VOICES-1:0]   voice_free
);

    localparam int O_W = $clog2(V_OSC);
    localparam logic [LEVEL_W-1:0] LVL_MAX = '1;

    env_state_t            state [VOICES];
    logic [LEVEL_W-1:0]    lvl   [VOICES];
    logic [SLOT_W-O_W-1:0] v;
    logic                  key;
    logic                  tick;
    logic [LEVEL_W:0]      up;
    logic [LEVEL_W:0]      down;

    assign v    = slot[SLOT_W-1:O_W];
    assign key  = reg_keys_on[v];
    assign tick = slot_valid && (slot[O_W-1:0] == '0);  // osc 0 slot only
    assign up   = {1'b0, lvl[v]} + {1'b0, attack_rate};
    assign down = {1'b0, lvl[v]} - {1'b0, release_rate};  // msb set on underflow

    always_comb begin
        for (int i = 0; i < VOICES; i++) begin
            voice_free[i] = (state[i] == env_idle);
        end
    end

    always_ff @(posedge audio_clk) begin
        if (rst) begin
            for (int i = 0; i < VOICES; i++) begin
                state[i] <= env_idle;
                lvl[i]   <= '0;
            end
            level <= '0;
        end else begin
            if (slot_valid) begin
                level <= lvl[v];  // value before this frame's update
            end
            if (tick) begin
                case (state[v])
                    env_idle: begin
                        if (key) state[v] <= env_attack;
                    end
                    env_attack: begin
                        if (!key) begin
                            state[v] <= env_release;
                        end else if (up[LEVEL_W] || up[LEVEL_W-1:0] == LVL_MAX) begin
                            lvl[v]   <= LVL_MAX;
                            state[v] <= env_sustain;
                        end else begin
                            lvl[v] <= up[LEVEL_W-1:0];
                        end
                    end
                    env_sustain: begin
                        if (!key) state[v] <= env_release;
                    end
                    env_release: begin
                        if (key) begin
                            state[v] <= env_attack;  // retrigger from current level
                        end else if (down[LEVEL_W] || down == '0) begin
                            lvl[v]   <= '0;
                            state[v] <= env_idle;
                        end else begin
                            lvl[v] <= down[LEVEL_W-1:0];
                        end
                    end
                    default: state[v] <= env_idle;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/voice_mixer.sv ====
`timescale 1ns/1ns
`default_nettype none

module voice_mixer import synth_pkg::*; #(
    parameter int VOICES        = 4,
    parameter int V_OSC         = 2,
    parameter int SLOT_W        = 3,
    parameter int AUD_BIT_DEPTH = 24
) (
    input  wire                       audio_clk,
    input  wire                       rst,
    input  wire  [SLOT_W-1:0]         slot,
    input  wire                       slot_valid,
    input  wire                       frame_end,
    input  wire signed [WAVE_W-1:0]   wave,
    input  wire  [LEVEL_W-1:0]        level,
    input  wire  [7:0]                velocity,
    input  wire  [7:0]                master_level,
    output logic [AUD_BIT_DEPTH-1:0]  lsound_out,
    output logic [AUD_BIT_DEPTH-1:0]  rsound_out,
    output logic                      sample_valid
);

    localparam int F_W = WAVE_W + LEVEL_W + 8 + 2;  // wave x level x velocity
    localparam int P_W = F_W - 15;                  // after >> 15
    localparam int A_W = P_W + $clog2(VOICES * V_OSC);

    logic                  v1;
    logic                  v2;
    logic                  end1;
    logic                  end2;
    logic                  odd1;
    logic                  odd2;
    logic signed [F_W-1:0] full;
    logic signed [P_W-1:0] p2;
    logic signed [P_W-1:0] add_l;
    logic signed [P_W-1:0] add_r;
    logic signed [A_W-1:0] acc_l;
    logic signed [A_W-1:0] acc_r;
    logic signed [A_W-1:0] frame_l;
    logic signed [A_W-1:0] frame_r;
    logic signed [A_W+8:0] scaled_l;
    logic signed [A_W+8:0] scaled_r;

    assign full  = wave * $signed({1'b0, level}) * $signed({1'b0, velocity});
    assign add_l = (v2 && !odd2) ? p2 : {P_W{1'b0}};  // even osc to left
    assign add_r = (v2 && odd2) ? p2 : {P_W{1'b0}};
    assign frame_l  = acc_l + add_l;
    assign frame_r  = acc_r + add_r;
    assign scaled_l = (frame_l * $signed({1'b0, master_level})) >>> 8;
    assign scaled_r = (frame_r * $signed({1'b0, master_level})) >>> 8;

    always_ff @(posedge audio_clk) begin
        odd1 <= slot[0];
        odd2 <= odd1;
        p2   <= full[F_W-1:15];
    end

    always_ff @(posedge audio_clk) begin
        if (rst) begin
            v1           <= 1'b0;
            v2           <= 1'b0;
            end1         <= 1'b0;
            end2         <= 1'b0;
            acc_l        <= '0;
            acc_r        <= '0;
            lsound_out   <= '0;
            rsound_out   <= '0;
            sample_valid <= 1'b0;
        end else begin
            v1           <= slot_valid;
            v2           <= v1;
            end1         <= frame_end;
            end2         <= end1;
            sample_valid <= v2 && end2;
            if (v2 && end2) begin                        // last product of the frame
                acc_l      <= '0;
                acc_r      <= '0;
                lsound_out <= AUD_BIT_DEPTH'(scaled_l);  // sign extended
                rsound_out <= AUD_BIT_DEPTH'(scaled_r);
            end else if (v2) begin
                acc_l <= frame_l;
                acc_r <= frame_r;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/synth_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module synth_engine import synth_pkg::*; #(
    parameter int VOICES        = 4,
    parameter int V_OSC         = 2,
    parameter int SLOT_W        = 3,   // slot index bits
    parameter int DAC_CREDITS   = 2,
    parameter int AUD_BIT_DEPTH = 24
) (
    input  wire                        audio_clk,
    input  wire                        rst,
    // note events
    input  wire  [VOICES-1:0]          keys_on,
    input  wire                        note_on,
    input  wire  [$clog2(VOICES)-1:0]  cur_key_adr,
    input  wire  [7:0]                 cur_vel_on,
    // register access
    input  wire                        write,
    input  wire                        read,
    input  wire  [ADR_W-1:0]           adr,
    input  wire  [DATA_W-1:0]          synth_data_in,
    output logic [DATA_W-1:0]          synth_data_out,
    // dac side
    input  wire                        credit_return,
    output logic [AUD_BIT_DEPTH-1:0]   lsound_out,
    output logic [AUD_BIT_DEPTH-1:0]   rsound_out,
    output logic                       sample_valid,
    output logic                       run,
    output logic [VOICES-1:0]          voice_free
);

    logic [SLOT_W-1:0]        slot;
    logic                     slot_valid;
    logic                     frame_start;
    logic                     frame_end;
    logic [VOICES-1:0]        reg_keys_on;
    logic [7:0]               velocity;
    logic [15:0]              phase_inc;
    logic [7:0]               attack_rate;
    logic [7:0]               release_rate;
    logic [7:0]               master_level;
    logic signed [WAVE_W-1:0] wave;
    logic [LEVEL_W-1:0]       level;

    slot_sequencer #(
        .VOICES(VOICES), .V_OSC(V_OSC), .SLOT_W(SLOT_W), .DAC_CREDITS(DAC_CREDITS)
    ) slot_sequencer_inst (
        .audio_clk     ( audio_clk ),
        .rst           ( rst ),
        .credit_return ( credit_return ),
        .slot          ( slot ),          // output
        .slot_valid    ( slot_valid ),    // output
        .frame_start   ( frame_start ),   // output
        .frame_end     ( frame_end ),     // output
        .run           ( run )            // output
    );

    note_latch #(.VOICES(VOICES), .V_OSC(V_OSC), .SLOT_W(SLOT_W)) note_latch_inst (
        .audio_clk   ( audio_clk ),
        .rst         ( rst ),
        .frame_start ( frame_start ),
        .keys_on     ( keys_on ),
        .note_on     ( note_on ),
        .cur_key_adr ( cur_key_adr ),
        .cur_vel_on  ( cur_vel_on ),
        .slot        ( slot ),
        .slot_valid  ( slot_valid ),
        .reg_keys_on ( reg_keys_on ),     // to env_gen
        .velocity    ( velocity )         // to mixer, t+1
    );

    param_regs #(.VOICES(VOICES), .V_OSC(V_OSC), .SLOT_W(SLOT_W)) param_regs_inst (
        .audio_clk      ( audio_clk ),
        .rst            ( rst ),
        .write          ( write ),
        .read           ( read ),
        .adr            ( adr ),
        .synth_data_in  ( synth_data_in ),
        .slot           ( slot ),
        .synth_data_out ( synth_data_out ),
        .phase_inc      ( phase_inc ),
        .attack_rate    ( attack_rate ),
        .release_rate   ( release_rate ),
        .master_level   ( master_level )
    );

    phase_accum #(.VOICES(VOICES), .V_OSC(V_OSC), .SLOT_W(SLOT_W)) phase_accum_inst (
        .audio_clk  ( audio_clk ),
        .rst        ( rst ),
        .slot       ( slot ),
        .slot_valid ( slot_valid ),
        .phase_inc  ( phase_inc ),
        .wave       ( wave )              // t+1
    );

    env_gen #(.VOICES(VOICES), .V_OSC(V_OSC), .SLOT_W(SLOT_W)) env_gen_inst (
        .audio_clk    ( audio_clk ),
        .rst          ( rst ),
        .slot         ( slot ),
        .slot_valid   ( slot_valid ),
        .reg_keys_on  ( reg_keys_on ),
        .attack_rate  ( attack_rate ),
        .release_rate ( release_rate ),
        .level        ( level ),          // t+1
        .voice_free   ( voice_free )
    );

    voice_mixer #(
        .VOICES(VOICES), .V_OSC(V_OSC), .SLOT_W(SLOT_W), .AUD_BIT_DEPTH(AUD_BIT_DEPTH)
    ) voice_mixer_inst (
        .audio_clk    ( audio_clk ),
        .rst          ( rst ),
        .slot         ( slot ),
        .slot_valid   ( slot_valid ),
        .frame_end    ( frame_end ),
        .wave         ( wave ),
        .level        ( level ),
        .velocity     ( velocity ),
        .master_level ( master_level ),
        .lsound_out   ( lsound_out ),
        .rsound_out   ( rsound_out ),
        .sample_valid ( sample_valid )    // t+3 after last slot
    );

endmodule

`default_nettype wire

// ==== tb/synth_engine_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module synth_engine_chk #(
    parameter int DAC_CREDITS = 2
) (
    input wire audio_clk,
    input wire rst,
    input wire frame_start,
    input wire credit_return,
    input wire run,
    input wire sample_valid
);

    int outstanding;  // frames started whose credit is not back yet
    int fails = 0;    // polled by the testbench

    always_ff @(posedge audio_clk) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(frame_start) - int'(credit_return);
        end
    end

    credit_bound: assert property (@(posedge audio_clk) disable iff (rst)
        outstanding <= DAC_CREDITS)
    else begin
        $error("more frames in flight than DAC credits");
        fails++;
    end

    // credit count is DAC_CREDITS - outstanding
    run_needs_credit: assert property (@(posedge audio_clk) disable iff (rst)
        (outstanding == DAC_CREDITS) |-> !run)
    else begin
        $error("run high with no credit held");
        fails++;
    end

    no_extra_return: assert property (@(posedge audio_clk) disable iff (rst)
        credit_return |-> (outstanding > 0))
    else begin
        $error("credit returned that was never taken");
        fails++;
    end

    sample_spacing: assert property (@(posedge audio_clk) disable iff (rst)
        sample_valid |=> !sample_valid [*7])
    else begin
        $error("sample_valid pulses closer than one frame");
        fails++;
    end

endmodule

bind synth_engine synth_engine_chk #(.DAC_CREDITS(DAC_CREDITS)) chk (
    .audio_clk     ( audio_clk ),
    .rst           ( rst ),
    .frame_start   ( frame_start ),
    .credit_return ( credit_return ),
    .run           ( run ),
    .sample_valid  ( sample_valid )
);

`default_nettype wire

// ==== tb/tb_synth_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_synth_engine import synth_pkg::*; ();

    localparam int VOICES         = 4;
    localparam int AUD_BIT_DEPTH  = 24;
    localparam int REG_FRAMES     = 8;   // frame budget per test
    localparam int SILENCE_FRAMES = 8;
    localparam int LIFE_FRAMES    = 30;
    localparam int ZERO_FRAMES    = 36;
    localparam int MARGIN_CYCLES  = 1000;
    localparam longint WATCHDOG_NS = longint'((REG_FRAMES + SILENCE_FRAMES + LIFE_FRAMES
        + ZERO_FRAMES) * 8 * 4 + MARGIN_CYCLES) * 100;

    logic                     audio_clk;
    logic                     rst;
    logic [VOICES-1:0]        keys_on;
    logic                     note_on;
    logic [1:0]               cur_key_adr;
    logic [7:0]               cur_vel_on;
    logic                     write;
    logic                     read;
    logic [ADR_W-1:0]         adr;
    logic [DATA_W-1:0]        synth_data_in;
    logic [DATA_W-1:0]        synth_data_out;
    logic                     credit_return;
    logic [AUD_BIT_DEPTH-1:0] lsound_out;
    logic [AUD_BIT_DEPTH-1:0] rsound_out;
    logic                     sample_valid;
    logic                     run;
    logic [VOICES-1:0]        voice_free;

    string       test_name = "reset";
    logic [31:0] lcg_state = 32'hbb1a1894;
    logic [7:0]  reg_model [128];    // expected register bytes
    int unsigned samples_seen = 0;   // samples delivered to the DAC model
    int unsigned credits_back = 0;

    synth_engine #(
        .VOICES(VOICES), .V_OSC(2), .SLOT_W(3), .DAC_CREDITS(2), .AUD_BIT_DEPTH(AUD_BIT_DEPTH)
    ) DUT (
        .audio_clk      ( audio_clk ),
        .rst            ( rst ),
        .keys_on        ( keys_on ),
        .note_on        ( note_on ),
        .cur_key_adr    ( cur_key_adr ),
        .cur_vel_on     ( cur_vel_on ),
        .write          ( write ),
        .read           ( read ),
        .adr            ( adr ),
        .synth_data_in  ( synth_data_in ),
        .synth_data_out ( synth_data_out ),
        .credit_return  ( credit_return ),
        .lsound_out     ( lsound_out ),
        .rsound_out     ( rsound_out ),
        .sample_valid   ( sample_valid ),
        .run            ( run ),
        .voice_free     ( voice_free )
    );

    initial begin
        audio_clk = 1'b0;
        forever #50 audio_clk = ~audio_clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // address map as the register spec defines it
    function automatic reg_block_t block_of(input logic [ADR_W-1:0] a);
        if (a < ADR_OSC_BASE + 7'd16) return blk_osc;
        if (a == ADR_ATTACK || a == ADR_RELEASE) return blk_env;
        if (a == ADR_MASTER) return blk_mix;
        return blk_none;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s: %s", test_name, msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_equal(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERR %s %s: expected 0x%0h actual 0x%0h", test_name, what, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic write_reg(input logic [ADR_W-1:0] a, input logic [DATA_W-1:0] d);
        @(posedge audio_clk);
        write         <= 1'b1;
        adr           <= a;
        synth_data_in <= d;
        @(posedge audio_clk);
        write <= 1'b0;
    endtask

    task automatic read_check(input logic [ADR_W-1:0] a);
        logic [DATA_W-1:0] exp;
        exp = (block_of(a) == blk_none) ? 8'h00 : reg_model[a];  // unmapped reads zero
        @(posedge audio_clk);
        read <= 1'b1;
        adr  <= a;
        @(posedge audio_clk);
        read <= 1'b0;
        @(negedge audio_clk);
        check_equal($sformatf("read 0x%02h", a), exp, synth_data_out);
    endtask

    task automatic note_event(input int v, input logic [7:0] vel);
        @(posedge audio_clk);
        note_on     <= 1'b1;
        cur_key_adr <= 2'(v);
        cur_vel_on  <= vel;
        @(posedge audio_clk);
        note_on <= 1'b0;
    endtask

    task automatic set_keys(input logic [VOICES-1:0] k);
        @(posedge audio_clk);
        keys_on <= k;
    endtask

    task automatic next_sample(output logic [AUD_BIT_DEPTH-1:0] l,
                               output logic [AUD_BIT_DEPTH-1:0] r);
        @(negedge audio_clk);
        while (!sample_valid) begin
            @(negedge audio_clk);
        end
        l = lsound_out;
        r = rsound_out;
    endtask

    task automatic check_silent(input int n);
        logic [AUD_BIT_DEPTH-1:0] l;
        logic [AUD_BIT_DEPTH-1:0] r;
        repeat (n) begin
            next_sample(l, r);
            check_equal("left sample", 32'h0, l);
            check_equal("right sample", 32'h0, r);
        end
    endtask

    task automatic flush_samples(input int n);
        logic [AUD_BIT_DEPTH-1:0] l;
        logic [AUD_BIT_DEPTH-1:0] r;
        repeat (n) next_sample(l, r);
    endtask

    // frames are counted by the samples that go by while waiting
    task automatic wait_voice(input int v, input logic want, input int limit,
                              input string what);
        int frames;
        frames = 0;
        @(negedge audio_clk);
        while (voice_free[v] !== want) begin
            if (sample_valid) frames++;
            assert (frames <= limit) else begin
                report_failure($sformatf("%s: voice %0d free bit not %0b within %0d frames",
                                         what, v, want, limit));
            end
            @(negedge audio_clk);
        end
    endtask

    always @(negedge audio_clk) begin
        if (!rst && sample_valid) samples_seen++;
    end

    initial begin : dac_model
        int gap;
        credit_return = 1'b0;
        forever begin
            @(posedge audio_clk);
            if (credits_back < samples_seen) begin
                gap = int'((next_rand() >> 16) % 32'd24);  // long gaps starve the engine
                repeat (gap) @(posedge audio_clk);
                credit_return <= 1'b1;
                @(posedge audio_clk);
                credit_return <= 1'b0;
                credits_back++;
            end
        end
    end

    initial begin
        wait (DUT.chk.fails != 0);
        $display("a protocol assertion in the checker failed during test %s", test_name);
        $display("Simulation finished: FAIL");
        $fatal(1);
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: test %s did not finish in time", test_name);
        $display("Simulation finished: FAIL");
        $fatal(1);
    end

    initial begin : main
        logic [31:0]              r;
        logic [ADR_W-1:0]         a;
        logic [AUD_BIT_DEPTH-1:0] snd_l;
        logic [AUD_BIT_DEPTH-1:0] snd_r;
        logic [7:0]               vel;
        logic                     seen;
        int                       v;
        int                       rel;
        int                       off_limit;
        rst           = 1'b1;
        keys_on       = '0;
        note_on       = 1'b0;
        cur_key_adr   = '0;
        cur_vel_on    = '0;
        write         = 1'b0;
        read          = 1'b0;
        adr           = '0;
        synth_data_in = '0;
        for (int i = 0; i < 128; i++) begin
            reg_model[i] = 8'h00;
        end

        repeat (2) @(posedge audio_clk);
        @(negedge audio_clk);
        check_equal("sample_valid", 32'h0, sample_valid);
        check_equal("run", 32'h0, run);
        check_equal("voice_free", 32'hf, voice_free);
        check_equal("lsound_out", 32'h0, lsound_out);
        check_equal("rsound_out", 32'h0, rsound_out);
        check_equal("synth_data_out", 32'h0, synth_data_out);
        @(posedge audio_clk);
        rst <= 1'b0;  // third reset cycle ends here

        test_name = "regs";
        repeat (40) begin
            r = next_rand();
            case (r[31:29])
                3'd0:    a = ADR_ATTACK;
                3'd1:    a = ADR_RELEASE;
                3'd2:    a = ADR_MASTER;
                3'd3:    a = r[22:16];  // mostly unmapped
                default: a = ADR_OSC_BASE + ADR_W'(r[19:16]);
            endcase
            write_reg(a, r[7:0]);
            if (block_of(a) != blk_none) reg_model[a] = r[7:0];
            read_check(a);
            read_check(r[15:9]);
        end
        read_check(7'h10);
        read_check(7'h22);
        read_check(7'h7f);

        test_name = "silence";
        check_equal("voice_free", 32'hf, voice_free);
        check_silent(8);

        test_name = "lifecycle";
        r   = next_rand();
        v   = int'(r[1:0]);
        rel = 32 + int'(r[13:8]);
        vel = {1'b1, r[22:16]};
        off_limit = (255 + rel - 1) / rel + 2;
        write_reg(ADR_ATTACK, 8'd64);
        write_reg(ADR_RELEASE, 8'(rel));
        write_reg(ADR_MASTER, 8'hff);
        write_reg(ADR_OSC_BASE + ADR_W'(4 * v), 8'h00);      // osc 0 increment 0x0400
        write_reg(ADR_OSC_BASE + ADR_W'(4 * v + 1), 8'h04);
        write_reg(ADR_OSC_BASE + ADR_W'(4 * v + 2), 8'h00);  // osc 1 increment 0x0300
        write_reg(ADR_OSC_BASE + ADR_W'(4 * v + 3), 8'h03);
        note_event(v, vel);
        set_keys(4'b0001 << v);
        wait_voice(v, 1'b0, 2, "key on");
        seen = 1'b0;
        repeat (8) begin
            next_sample(snd_l, snd_r);
            if (snd_l != 0 || snd_r != 0) seen = 1'b1;
        end
        assert (seen) else begin
            report_failure("every sample stayed zero while the voice was busy");
        end
        set_keys('0);
        wait_voice(v, 1'b1, off_limit, "key off");

        test_name = "zero_master";
        flush_samples(2);  // last frame still carries the old level
        write_reg(ADR_MASTER, 8'h00);
        note_event(v, vel);
        set_keys(4'b0001 << v);
        wait_voice(v, 1'b0, 2, "key on");
        check_silent(6);
        set_keys('0);
        wait_voice(v, 1'b1, off_limit, "key off");
        flush_samples(2);

        test_name = "zero_velocity";
        write_reg(ADR_MASTER, 8'hff);
        note_event(v, 8'h00);
        set_keys(4'b0001 << v);
        wait_voice(v, 1'b0, 2, "key on");
        check_silent(6);

        if (DUT.chk.fails == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/synth_pkg.sv
rtl/slot_sequencer.sv
rtl/note_latch.sv
rtl/param_regs.sv
rtl/phase_accum.sv
rtl/env_gen.sv
rtl/voice_mixer.sv
rtl/synth_engine.sv
tb/synth_engine_chk.sv
tb/tb_synth_engine.sv
